//--- vlog.f
design/bu_pkg.sv
design/branch_predictor.sv
design/branch_resolve.sv
design/branch_unit_top.sv
bench/tb_clock.sv
bench/branch_unit_properties.sv
bench/branch_unit_tb.sv

//--- Bender.yml
package:
  name: branch_unit

sources:
  - design/bu_pkg.sv
  - design/branch_predictor.sv
  - design/branch_resolve.sv
  - design/branch_unit_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/branch_unit_properties.sv
      - bench/branch_unit_tb.sv

//--- bench/branch_unit_tb.sv
/*
 * Branch unit testbench
 * Seeded random instruction mix against a cycle model of the
 * resolver, the global history and the counter table
 */

`timescale 1ns/10ps

module branch_unit_tb;

  localparam int unsigned BP_GLOBAL_BITS = 2;
  localparam int unsigned BP_INDEX_BITS  = 6;
  localparam int unsigned ENTRIES        = 2 ** BP_INDEX_BITS;

  // jalr x1, 0(x1) and addi x0, x0, 0
  localparam bu_pkg::xlen_t jalr_word = {12'h000, 5'd1, 3'b000, 5'd1, bu_pkg::opc_jalr};
  localparam bu_pkg::xlen_t nop_word  = 32'h0000_0013;

  logic            clk_i;
  logic            rst_ni;
  logic            id_valid;
  bu_pkg::xlen_t   id_pc;
  bu_pkg::xlen_t   id_insn;
  bu_pkg::xlen_t   op_a;
  bu_pkg::xlen_t   op_b;
  logic            id_mis;
  logic            ex_stall;
  logic            squash;
  logic            du_we;
  bu_pkg::xlen_t   du_dato;
  logic            du_stall;
  bu_pkg::xlen_t   nxt_pc;
  logic            flush;
  logic            cacheflush;
  logic            misaligned;
  bu_pkg::bp_cnt_t bp_predict;
  logic            bp_btaken;
  logic            bp_update;

  // Side inputs for the next step
  logic            nx_mis;
  logic            nx_stall;
  logic            nx_squash;
  logic            nx_du_we;
  logic            nx_du_stall;
  bu_pkg::xlen_t   nx_du_dato;

  ////////////////////
  // Reference model
  ////////////////////

  bu_pkg::bp_cnt_t           m_table [ENTRIES];
  logic [BP_GLOBAL_BITS:0]   m_hist;
  logic [BP_INDEX_BITS-1:0]  m_upd_idx;
  logic                      m_du_wrote;
  // Expected outputs after the coming edge
  bu_pkg::xlen_t             e_nxt;
  logic                      e_flush;
  logic                      e_cache;
  logic                      e_mis;
  logic                      e_bt;
  logic                      e_upd;
  bu_pkg::bp_cnt_t           e_pred;

  string cur_test;
  int    n_checks;
  int    n_err;
  int    test_err0;
  int    n_pass;
  int    n_fail;
  bit    rst_ok;

  tb_clock #(.RESET_CYCLES(16)) u_clk (.clk_o(clk_i), .rst_no(rst_ni));

  branch_unit_top #(
    .BP_GLOBAL_BITS (BP_GLOBAL_BITS),
    .BP_INDEX_BITS  (BP_INDEX_BITS),
    .HAS_RVC        (1'b0)
  ) dut0 (
    .clk_i (clk_i), .rst_ni (rst_ni), .id_valid_i (id_valid), .id_pc_i (id_pc),
    .id_insn_i (id_insn), .op_a_i (op_a), .op_b_i (op_b), .id_misaligned_i (id_mis),
    .ex_stall_i (ex_stall), .squash_i (squash), .du_we_pc_i (du_we),
    .du_dato_i (du_dato), .du_stall_i (du_stall), .nxt_pc_o (nxt_pc), .flush_o (flush),
    .cacheflush_o (cacheflush), .misaligned_o (misaligned), .bp_predict_o (bp_predict),
    .bp_btaken_o (bp_btaken), .bp_update_o (bp_update)
  );

  bind branch_unit_top branch_unit_properties u_props (.*);

  task automatic check_val(input string what, input bu_pkg::xlen_t exp_v,
                           input bu_pkg::xlen_t act_v);
    n_checks++;
    assert (act_v === exp_v) else begin
      $display("FAILED %s %s: expected %h actual %h", cur_test, what, exp_v, act_v);
      n_err++;
    end
  endtask

  // Saturating move toward the outcome
  function automatic bu_pkg::bp_cnt_t counter_step(input bu_pkg::bp_cnt_t c, input logic t);
    if (t) begin
      return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
  endfunction

  // Signed order by flipping the sign bits
  function automatic logic signed_less(input bu_pkg::xlen_t a, input bu_pkg::xlen_t b);
    return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
  endfunction

  // Model of the edge that samples the inputs now on the DUT pins
  task automatic predict_next();
    bu_pkg::xlen_t            fall;
    bu_pkg::xlen_t            tgt;
    bu_pkg::xlen_t            imm_b;
    bu_pkg::xlen_t            imm_j;
    logic [BP_INDEX_BITS-1:0] idx;
    bu_pkg::bp_cnt_t          cnt;
    logic                     cond;
    logic                     taken;
    logic                     upd;
    logic                     pf;
    logic                     cf;
    logic                     xfer;
    logic                     ovr;
    fall  = id_pc + 32'd4;
    tgt   = fall;
    imm_b = {{20{id_insn[31]}}, id_insn[7], id_insn[30:25], id_insn[11:8], 1'b0};
    imm_j = {{12{id_insn[31]}}, id_insn[19:12], id_insn[20], id_insn[30:21], 1'b0};
    // Lookup sees the table before this edge's write
    idx   = id_pc[BP_INDEX_BITS+1:2] ^ BP_INDEX_BITS'(m_hist[BP_GLOBAL_BITS:1]);
    cnt   = m_table[idx];
    if (e_upd) begin
      m_table[m_upd_idx] = counter_step(e_pred, e_bt);
    end
    if (!ex_stall) begin
      m_upd_idx = idx;
    end
    {cond, taken, upd, pf, cf, xfer} = '0;
    case (id_insn[14:12])
      3'b000:  cond = (op_a == op_b);
      3'b001:  cond = (op_a != op_b);
      3'b100:  cond = signed_less(op_a, op_b);
      3'b101:  cond = !signed_less(op_a, op_b);
      3'b110:  cond = (op_a < op_b);
      3'b111:  cond = !(op_a < op_b);
      default: cond = 1'b0;
    endcase
    if (id_valid) begin
      case (id_insn[6:0])
        bu_pkg::opc_jal: begin
          {taken, xfer, pf} = {2'b11, !cnt[1]};
          tgt = id_pc + imm_j;
        end
        bu_pkg::opc_jalr: begin
          {taken, xfer, pf} = 3'b111;
          tgt = (op_a + op_b) & ~32'd1;
        end
        bu_pkg::opc_branch: begin
          // funct3 010 and 011 are not branches
          if (id_insn[14] || !id_insn[13]) begin
            {taken, upd, xfer} = {cond, 2'b11};
            pf = cond ^ cnt[1];
            tgt = cond ? id_pc + imm_b : fall;
          end
        end
        bu_pkg::opc_miscmem: begin
          if (id_insn == bu_pkg::fence_i_word) begin
            {pf, cf} = 2'b11;
          end
        end
        default: ;
      endcase
    end
    // Flag clears on the flush already on the output
    if (!ex_stall) begin
      if (e_flush || squash) begin
        e_mis = 1'b0;
      end else if (!du_stall) begin
        e_mis = id_mis | (xfer & (|tgt[1:0]));
      end
    end
    ovr        = du_we | (m_du_wrote & du_stall);
    m_du_wrote = ovr;
    if (du_we) begin
      e_nxt = du_dato;
    end else if (!ovr && !ex_stall) begin
      e_nxt = tgt;
    end
    if (ovr) begin
      {e_flush, e_cache, e_bt, e_upd, e_pred} = {du_we, 5'b0};
    end else begin
      {e_flush, e_cache, e_bt, e_upd, e_pred} = {pf, cf, taken, upd, cnt};
      if (upd) begin
        m_hist = {m_hist[BP_GLOBAL_BITS-1:0], taken};
      end
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Drive one cycle, check the previous one, then model this one
  task automatic step(input logic v, input bu_pkg::xlen_t pc, input bu_pkg::xlen_t insn,
                      input bu_pkg::xlen_t a, input bu_pkg::xlen_t b);
    @(posedge clk_i);
    id_valid <= v;
    id_pc    <= pc;
    id_insn  <= insn;
    op_a     <= a;
    op_b     <= b;
    id_mis   <= nx_mis;
    ex_stall <= nx_stall;
    squash   <= nx_squash;
    du_we    <= nx_du_we;
    du_dato  <= nx_du_dato;
    du_stall <= nx_du_stall;
    #1;
    check_val("nxt_pc_o", e_nxt, nxt_pc);
    check_val("flush_o", e_flush, flush);
    check_val("cacheflush_o", e_cache, cacheflush);
    check_val("misaligned_o", e_mis, misaligned);
    check_val("bp_predict_o", e_pred, bp_predict);
    check_val("bp_btaken_o", e_bt, bp_btaken);
    check_val("bp_update_o", e_upd, bp_update);
    predict_next();
  endtask

  function automatic bu_pkg::xlen_t mk_branch(input logic [2:0] f3, input logic [12:0] imm);
    bu_pkg::insn_u w;
    w            = '0;
    w.sb.opcode  = bu_pkg::opc_branch;
    w.sb.funct3  = f3;
    w.sb.rs1     = 5'd1;
    w.sb.rs2     = 5'd2;
    w.sb.imm12   = imm[12];
    w.sb.imm11   = imm[11];
    w.sb.imm10_5 = imm[10:5];
    w.sb.imm4_1  = imm[4:1];
    return w;
  endfunction

  function automatic bu_pkg::xlen_t mk_jal(input logic [20:0] imm);
    bu_pkg::insn_u w;
    w             = '0;
    w.uj.opcode   = bu_pkg::opc_jal;
    w.uj.rd       = 5'd1;
    w.uj.imm20    = imm[20];
    w.uj.imm19_12 = imm[19:12];
    w.uj.imm11    = imm[11];
    w.uj.imm10_1  = imm[10:1];
    return w;
  endfunction

  function automatic logic [2:0] pick_f3();
    case ($urandom_range(0, 5))
      0:       return bu_pkg::f3_beq;
      1:       return bu_pkg::f3_bne;
      2:       return bu_pkg::f3_blt;
      3:       return bu_pkg::f3_bge;
      4:       return bu_pkg::f3_bltu;
      default: return bu_pkg::f3_bgeu;
    endcase
  endfunction

  // Sign boundaries show up often
  function automatic bu_pkg::xlen_t rand_operand();
    case ($urandom_range(0, 6))
      0:       return 32'h8000_0000;
      1:       return 32'h7FFF_FFFF;
      2:       return 32'hFFFF_FFFF;
      3:       return 32'h0000_0000;
      default: return $urandom();
    endcase
  endfunction

  function automatic bu_pkg::xlen_t rand_pc();
    return $urandom() & ~32'd3;
  endfunction

  task automatic random_branch_step();
    bu_pkg::xlen_t a;
    bu_pkg::xlen_t b;
    a = rand_operand();
    b = ($urandom_range(0, 3) == 0) ? a : rand_operand();
    step(1'b1, rand_pc(), mk_branch(pick_f3(), 13'($urandom()) & 13'h1FFC), a, b);
  endtask

  task automatic random_any_step();
    case ($urandom_range(0, 5))
      0: random_branch_step();
      1: step(1'b1, rand_pc(), mk_jal(21'($urandom()) & 21'h1F_FFFC), 32'd0, 32'd0);
      2: step(1'b1, rand_pc(), jalr_word, rand_operand(), rand_operand());
      3: step(1'b1, rand_pc(), bu_pkg::fence_i_word, 32'd0, 32'd0);
      4: step(1'b1, rand_pc(), ($urandom() & ~32'h7F) | 32'h33, rand_operand(), 32'd0);
      // Bubble carrying junk
      default: step(1'b0, rand_pc(), $urandom(), rand_operand(), rand_operand());
    endcase
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_err0 = n_err;
  endtask

  task automatic end_test();
    step(1'b0, id_pc, nop_word, 32'd0, 32'd0);
    if (n_err == test_err0) begin
      n_pass++;
      $display("test %s passed", cur_test);
    end else begin
      n_fail++;
      $display("test %s failed with %0d errors", cur_test, n_err - test_err0);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int   waited;
    int   periods;
    logic miss;
    void'($urandom(99563));
    {id_valid, id_mis, ex_stall, squash, du_we, du_stall} = '0;
    {id_pc, id_insn, op_a, op_b, du_dato} = '0;
    {nx_mis, nx_stall, nx_squash, nx_du_we, nx_du_stall, nx_du_dato} = '0;
    {n_checks, n_err, n_pass, n_fail} = '0;
    waited = 0;
    while (!rst_ni && waited < 100) begin
      @(negedge clk_i);
      waited++;
    end
    rst_ok = rst_ni;
    assert (rst_ok) else begin
      $display("reset was not released within 100 cycles");
      n_err++;
    end
    if (rst_ok) begin
      begin_test("reset_state");
      check_val("nxt_pc_o", 32'h0000_0200, nxt_pc);
      check_val("flush_o", 32'd1, flush);
      check_val("cacheflush_o", 32'd0, cacheflush);
      check_val("misaligned_o", 32'd0, misaligned);
      check_val("bp_btaken_o", 32'd0, bp_btaken);
      check_val("bp_update_o", 32'd0, bp_update);
      check_val("bp_predict_o", 32'd0, bp_predict);
      foreach (m_table[i]) m_table[i] = 2'd1;
      {m_hist, m_upd_idx, m_du_wrote} = '0;
      e_nxt = 32'h0000_0200;
      {e_flush, e_cache, e_mis, e_bt, e_upd, e_pred} = 7'b100_0000;
      predict_next();
      end_test();

      begin_test("branch_resolution");
      repeat (80) begin
        if ($urandom_range(0, 4) == 0) begin
          step(1'b0, rand_pc(), nop_word, 32'd0, 32'd0);
        end else begin
          random_branch_step();
        end
      end
      end_test();

      begin_test("jumps_and_fence");
      step(1'b1, 32'h0000_0400, bu_pkg::fence_i_word, 32'd0, 32'd0);
      repeat (80) random_any_step();
      end_test();

      // Taken, taken, not taken at one PC until no mispredict in a period
      begin_test("predictor_training");
      periods = 0;
      miss    = 1'b1;
      while (miss && periods < 40) begin
        miss = 1'b0;
        for (int i = 0; i < 3; i++) begin
          step(1'b1, 32'h0000_1040, mk_branch(bu_pkg::f3_beq, 13'h0040),
               32'd5, (i == 2) ? 32'd6 : 32'd5);
          step(1'b0, 32'h0000_1044, nop_word, 32'd0, 32'd0);
          miss = miss | flush;
        end
        periods++;
      end
      assert (!miss) else begin
        $display("predictor still mispredicting after 40 training periods");
        n_err++;
      end
      end_test();

      begin_test("misalign_and_squash");
      step(1'b0, 32'h0000_3000, nop_word, 32'd0, 32'd0);
      step(1'b1, 32'h0000_3000, mk_jal(21'h000102), 32'd0, 32'd0);
      step(1'b0, 32'h0000_3004, nop_word, 32'd0, 32'd0);
      nx_mis = 1'b1;
      step(1'b0, 32'h0000_3008, nop_word, 32'd0, 32'd0);
      nx_squash = 1'b1;
      step(1'b0, 32'h0000_300C, nop_word, 32'd0, 32'd0);
      {nx_mis, nx_squash} = 2'b00;
      step(1'b1, 32'h0000_3010, jalr_word, 32'h0000_0100, 32'h0000_0003);
      repeat (40) begin
        nx_mis    = ($urandom_range(0, 3) == 0);
        nx_squash = ($urandom_range(0, 3) == 0);
        random_any_step();
      end
      {nx_mis, nx_squash} = 2'b00;
      end_test();

      begin_test("debug_and_stall");
      step(1'b0, 32'h0000_5000, nop_word, 32'd0, 32'd0);
      {nx_du_we, nx_du_stall, nx_du_dato} = {2'b11, rand_pc()};
      random_branch_step();
      nx_du_we = 1'b0;
      repeat (4) random_branch_step();
      nx_du_stall = 1'b0;
      repeat (3) random_branch_step();
      nx_stall = 1'b1;
      repeat (4) random_any_step();
      repeat (30) begin
        nx_stall = ($urandom_range(0, 2) == 0);
        random_any_step();
      end
      nx_stall = 1'b0;
      end_test();
    end

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             n_pass, n_fail, n_checks, n_err);
    if (n_err == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- bench/branch_unit_properties.sv
/*
 * Branch unit properties
 * Concurrent checks on the flush outputs and the debug PC write
 */

`timescale 1ns/10ps

module branch_unit_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic du_we_pc_i,
  input logic flush_o,
  input logic cacheflush_o,
  input logic bp_update_o
);

  // Cache flush never comes alone
  cacheflush_needs_flush: assert property (
    @(posedge clk_i) disable iff (!rst_ni) cacheflush_o |-> flush_o
  ) else $error("cache flush raised without a pipeline flush");

  // Debug write suppresses the predictor update
  no_update_after_du_write: assert property (
    @(posedge clk_i) disable iff (!rst_ni) du_we_pc_i |=> !bp_update_o
  ) else $error("predictor update in the cycle after a debug PC write");

  // Start-up pipeline gets flushed
  flush_out_of_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> flush_o
  ) else $error("flush low in the first cycle after reset");

endmodule

//--- bench/tb_clock.sv
/*
 * Testbench clock and reset
 * 4 ns clock, active-low reset held for a number of rising edges
 */

`timescale 1ns/10ps

module tb_clock #(
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release just after an edge so no flop sees it at the edge itself
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

//--- design/branch_unit_top.sv
/*
 * Branch unit top level
 * Predictor and resolver of the branch resolution stage
 */

`timescale 1ns/10ps

module branch_unit_top #(
  parameter int unsigned BP_GLOBAL_BITS = 2,
  parameter int unsigned BP_INDEX_BITS  = 6,
  parameter bit          HAS_RVC        = 1'b0
) (
  input  logic            clk_i,
  input  logic            rst_ni,

  // Stage inputs
  input  logic            id_valid_i,
  input  bu_pkg::xlen_t   id_pc_i,
  input  bu_pkg::insn_u   id_insn_i,
  input  bu_pkg::xlen_t   op_a_i,
  input  bu_pkg::xlen_t   op_b_i,
  input  logic            id_misaligned_i,
  input  logic            ex_stall_i,
  input  logic            squash_i,

  // Debug port
  input  logic            du_we_pc_i,
  input  bu_pkg::xlen_t   du_dato_i,
  input  logic            du_stall_i,

  // Stage outputs
  output bu_pkg::xlen_t   nxt_pc_o,
  output logic            flush_o,
  output logic            cacheflush_o,
  output logic            misaligned_o,
  output bu_pkg::bp_cnt_t bp_predict_o,
  output logic            bp_btaken_o,
  output logic            bp_update_o
);

  bu_pkg::bp_cnt_t           lookup_cnt;
  logic [BP_GLOBAL_BITS-1:0] bp_history;

  ////////////////////
  // Predictor
  ////////////////////

  // Trained by the resolver's registered outcome
  branch_predictor #(
    .BP_GLOBAL_BITS (BP_GLOBAL_BITS),
    .BP_INDEX_BITS  (BP_INDEX_BITS)
  ) u_pred (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ex_stall_i   (ex_stall_i),
    .id_pc_i      (id_pc_i),
    .bp_history_i (bp_history),
    .lookup_cnt_o (lookup_cnt),
    .upd_i        (bp_update_o),
    .upd_taken_i  (bp_btaken_o),
    .upd_cnt_i    (bp_predict_o)
  );

  ////////////////////
  // Resolver
  ////////////////////

  branch_resolve #(
    .BP_GLOBAL_BITS (BP_GLOBAL_BITS),
    .HAS_RVC        (HAS_RVC)
  ) u_res (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ex_stall_i      (ex_stall_i),
    .squash_i        (squash_i),
    .id_valid_i      (id_valid_i),
    .id_pc_i         (id_pc_i),
    .id_insn_i       (id_insn_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .id_bp_predict_i (lookup_cnt),
    .id_misaligned_i (id_misaligned_i),
    .du_we_pc_i      (du_we_pc_i),
    .du_dato_i       (du_dato_i),
    .du_stall_i      (du_stall_i),
    .nxt_pc_o        (nxt_pc_o),
    .flush_o         (flush_o),
    .cacheflush_o    (cacheflush_o),
    .misaligned_o    (misaligned_o),
    .bp_predict_o    (bp_predict_o),
    .bp_btaken_o     (bp_btaken_o),
    .bp_update_o     (bp_update_o),
    .bp_history_o    (bp_history)
  );

endmodule

//--- design/branch_resolve.sv
/*
 * Branch resolver
 * Resolves JAL, JALR, conditional branches and FENCE.I, registers the
 * next PC, pipeline and cache flush, branch outcome and global history.
 * Also handles the debugger's next-PC override
 */

`timescale 1ns/10ps

module branch_resolve #(
  parameter int unsigned BP_GLOBAL_BITS = 2,
  parameter bit          HAS_RVC        = 1'b0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      ex_stall_i,
  input  logic                      squash_i,

  // Decoded instruction from ID
  input  logic                      id_valid_i,
  input  bu_pkg::xlen_t             id_pc_i,
  input  bu_pkg::insn_u             id_insn_i,
  input  bu_pkg::xlen_t             op_a_i,
  input  bu_pkg::xlen_t             op_b_i,
  input  bu_pkg::bp_cnt_t           id_bp_predict_i,
  input  logic                      id_misaligned_i,

  // Debug port
  input  logic                      du_we_pc_i,
  input  bu_pkg::xlen_t             du_dato_i,
  input  logic                      du_stall_i,

  output bu_pkg::xlen_t             nxt_pc_o,
  output logic                      flush_o,
  output logic                      cacheflush_o,
  output logic                      misaligned_o,
  output bu_pkg::bp_cnt_t           bp_predict_o,
  output logic                      bp_btaken_o,
  output logic                      bp_update_o,
  output logic [BP_GLOBAL_BITS-1:0] bp_history_o
);

  ////////////////////
  // Decode
  ////////////////////

  logic                    is_16bit;
  bu_pkg::xlen_t           ext_imm_sb;
  bu_pkg::xlen_t           ext_imm_uj;
  bu_pkg::xlen_t           fall_pc;

  // Branch compare
  logic                    br_known;
  logic                    br_cond;

  // Resolution result
  logic                    btaken;
  logic                    bp_update;
  logic                    pipeflush;
  logic                    cacheflush;
  logic                    is_xfer;
  logic                    misaligned;
  bu_pkg::xlen_t           nxt_pc;

  // Debug override
  logic                    du_wrote_pc;
  logic                    du_override;

  // One extra bit holds the newest outcome
  logic [BP_GLOBAL_BITS:0] bp_history;

  // Compressed only when RVC is on and the low bits are not 2'b11
  assign is_16bit = HAS_RVC && (id_insn_i.sb.opcode[1:0] != 2'b11);
  assign fall_pc  = id_pc_i + (is_16bit ? 32'd2 : 32'd4);

  // Reassemble the scattered immediates, bit 0 is always zero
  assign ext_imm_sb = {{19{id_insn_i.sb.imm12}}, id_insn_i.sb.imm12, id_insn_i.sb.imm11,
                       id_insn_i.sb.imm10_5, id_insn_i.sb.imm4_1, 1'b0};
  assign ext_imm_uj = {{11{id_insn_i.uj.imm20}}, id_insn_i.uj.imm20, id_insn_i.uj.imm19_12,
                       id_insn_i.uj.imm11, id_insn_i.uj.imm10_1, 1'b0};

  // Condition per funct3, unknown codes never branch
  always_comb begin
    br_known = 1'b1;
    br_cond  = 1'b0;
    case (id_insn_i.sb.funct3)
      bu_pkg::f3_beq:  br_cond = (op_a_i == op_b_i);
      bu_pkg::f3_bne:  br_cond = (op_a_i != op_b_i);
      bu_pkg::f3_blt:  br_cond = ($signed(op_a_i) < $signed(op_b_i));
      bu_pkg::f3_bge:  br_cond = ($signed(op_a_i) >= $signed(op_b_i));
      bu_pkg::f3_bltu: br_cond = (op_a_i < op_b_i);
      bu_pkg::f3_bgeu: br_cond = (op_a_i >= op_b_i);
      default:         br_known = 1'b0;
    endcase
  end

  ////////////////////
  // Resolve
  ////////////////////

  always_comb begin
    btaken     = 1'b0;
    bp_update  = 1'b0;
    pipeflush  = 1'b0;
    cacheflush = 1'b0;
    is_xfer    = 1'b0;
    nxt_pc     = fall_pc;
    if (id_valid_i) begin
      case (id_insn_i.sb.opcode)
        bu_pkg::opc_jal: begin
          btaken    = 1'b1;
          is_xfer   = 1'b1;
          // Fetch already followed a taken prediction
          pipeflush = ~id_bp_predict_i[1];
          nxt_pc    = id_pc_i + ext_imm_uj;
        end
        bu_pkg::opc_jalr: begin
          btaken    = 1'b1;
          is_xfer   = 1'b1;
          pipeflush = 1'b1;
          nxt_pc    = (op_a_i + op_b_i) & ~32'd1;
        end
        bu_pkg::opc_branch: begin
          if (br_known) begin
            btaken    = br_cond;
            bp_update = 1'b1;
            is_xfer   = 1'b1;
            // Mispredict when outcome and prediction disagree
            pipeflush = br_cond ^ id_bp_predict_i[1];
            nxt_pc    = br_cond ? id_pc_i + ext_imm_sb : fall_pc;
          end
        end
        bu_pkg::opc_miscmem: begin
          // FENCE.I refetches through a clean cache
          if (id_insn_i == bu_pkg::fence_i_word) begin
            pipeflush  = 1'b1;
            cacheflush = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // Halfword alignment is enough with RVC
  assign misaligned = id_misaligned_i |
                      (is_xfer & (HAS_RVC ? nxt_pc[0] : |nxt_pc[1:0]));

  ////////////////////
  // Debug override
  ////////////////////

  // Active on the write itself and while the debugger keeps the stall
  assign du_override = du_we_pc_i | (du_wrote_pc & du_stall_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      du_wrote_pc <= 1'b0;
    end else begin
      du_wrote_pc <= du_override;
    end
  end

  ////////////////////
  // Output registers
  ////////////////////

  // Flush and predictor outputs are not held by the EX stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_o      <= 1'b1;
      cacheflush_o <= 1'b0;
      bp_predict_o <= '0;
      bp_btaken_o  <= 1'b0;
      bp_update_o  <= 1'b0;
      bp_history   <= '0;
    end else if (du_override) begin
      // Flush once for the new PC then stay quiet
      flush_o      <= du_we_pc_i;
      cacheflush_o <= 1'b0;
      bp_predict_o <= '0;
      bp_btaken_o  <= 1'b0;
      bp_update_o  <= 1'b0;
    end else begin
      flush_o      <= pipeflush;
      cacheflush_o <= cacheflush;
      bp_predict_o <= id_bp_predict_i;
      bp_btaken_o  <= btaken;
      bp_update_o  <= bp_update;
      // Shift register of conditional branch outcomes
      if (bp_update) begin
        bp_history <= {bp_history[BP_GLOBAL_BITS-1:0], btaken};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nxt_pc_o <= bu_pkg::pc_reset_value;
    end else if (du_we_pc_i) begin
      nxt_pc_o <= du_dato_i;
    end else if (!du_override && !ex_stall_i) begin
      nxt_pc_o <= nxt_pc;
    end
  end

  // Wrong-path instructions lose their fault
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      misaligned_o <= 1'b0;
    end else if (!ex_stall_i) begin
      if (flush_o || squash_i) begin
        misaligned_o <= 1'b0;
      end else if (!du_stall_i) begin
        misaligned_o <= misaligned;
      end
    end
  end

  // Lookup must not see the branch's own newest outcome
  assign bp_history_o = bp_history[BP_GLOBAL_BITS:1];

endmodule

//--- design/branch_predictor.sv
/*
 * Global-history branch predictor
 * Table of two-bit saturating counters indexed by PC xor history,
 * combinational lookup and a one-cycle-late update
 */

`timescale 1ns/10ps

module branch_predictor #(
  parameter int unsigned BP_GLOBAL_BITS = 2,
  parameter int unsigned BP_INDEX_BITS  = 6
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      ex_stall_i,

  // Lookup side
  input  bu_pkg::xlen_t             id_pc_i,
  input  logic [BP_GLOBAL_BITS-1:0] bp_history_i,
  output bu_pkg::bp_cnt_t           lookup_cnt_o,

  // Update side, registered outcome from the resolver
  input  logic                      upd_i,
  input  logic                      upd_taken_i,
  input  bu_pkg::bp_cnt_t           upd_cnt_i
);

  localparam int unsigned ENTRIES = 2 ** BP_INDEX_BITS;

  ////////////////////
  // Index
  ////////////////////

  logic [BP_INDEX_BITS-1:0] hist_fold;
  logic [BP_INDEX_BITS-1:0] lookup_idx;
  logic [BP_INDEX_BITS-1:0] upd_idx;
  bu_pkg::bp_cnt_t          cnt_next;
  bu_pkg::bp_cnt_t          cnt_table [ENTRIES];

  // History lands on the low index bits
  assign hist_fold  = BP_INDEX_BITS'(bp_history_i);

  // Word address bits, instruction bits [1:0] skipped
  assign lookup_idx = id_pc_i[BP_INDEX_BITS+1:2] ^ hist_fold;

  assign lookup_cnt_o = cnt_table[lookup_idx];

  // Lines up with the resolver's outcome one cycle later
  always_ff @(posedge clk_i) begin
    if (!ex_stall_i) begin
      upd_idx <= lookup_idx;
    end
  end

  ////////////////////
  // Update
  ////////////////////

  // One step toward the outcome from the counter seen at lookup
  always_comb begin
    cnt_next = upd_cnt_i;
    if (upd_taken_i) begin
      if (upd_cnt_i != bu_pkg::bp_cnt_max) begin
        cnt_next = upd_cnt_i + 2'd1;
      end
    end else begin
      if (upd_cnt_i != bu_pkg::bp_cnt_min) begin
        cnt_next = upd_cnt_i - 2'd1;
      end
    end
  end

  // All entries start weakly not taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < ENTRIES; i++) begin
        cnt_table[i] <= bu_pkg::bp_cnt_init;
      end
    end else if (upd_i) begin
      cnt_table[upd_idx] <= cnt_next;
    end
  end

endmodule

//--- design/bu_pkg.sv
/*
 * Branch unit package
 * Shared word types, RV32 control-transfer opcodes, the instruction
 * union with its SB and UJ views, and the two-bit predictor counter
 */

package bu_pkg;

  ////////////////////
  // Word types
  ////////////////////

  // Data and address word
  typedef logic [31:0] xlen_t;

  // Reset vector
  localparam xlen_t pc_reset_value = 32'h0000_0200;

  ////////////////////
  // Opcodes
  ////////////////////

  localparam logic [6:0] opc_branch  = 7'b1100011;
  localparam logic [6:0] opc_jal     = 7'b1101111;
  localparam logic [6:0] opc_jalr    = 7'b1100111;
  localparam logic [6:0] opc_miscmem = 7'b0001111;

  // Conditional branch funct3 codes
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // FENCE.I with rd, rs1 and imm all zero
  localparam logic [31:0] fence_i_word = 32'h0000_100F;

  ////////////////////
  // Instruction word
  ////////////////////

  // Same 32 bits seen as a branch (SB) or as a jump (UJ)
  typedef union packed {
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } sb;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } uj;
  } insn_u;

  ////////////////////
  // Predictor encoding
  ////////////////////

  // Bit 1 set means predict taken
  typedef logic [1:0] bp_cnt_t;

  // 0 strongly not taken, 3 strongly taken
  localparam bp_cnt_t bp_cnt_min  = 2'd0;
  localparam bp_cnt_t bp_cnt_init = 2'd1;
  localparam bp_cnt_t bp_cnt_max  = 2'd3;

endpackage
